// ==== common/alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// operand width of the unit.
`define ALU_WIDTH 32

// width of the external opcode field.
`define ALU_OPC_W 5

`endif

// ==== common/alu_pkg.sv ====
`include "alu_cfg.svh"

package alu_pkg;

  // external opcodes, everything above opc_mfhi is illegal.
  typedef enum logic [`ALU_OPC_W-1:0] {
    opc_add  = 5'h00,
    opc_sub  = 5'h01,
    opc_mul  = 5'h02,
    opc_lui  = 5'h03,
    opc_shl  = 5'h04,
    opc_shr  = 5'h05,
    opc_asl  = 5'h06,
    opc_asr  = 5'h07,
    opc_and  = 5'h08,
    opc_or   = 5'h09,
    opc_xor  = 5'h0a,
    opc_nor  = 5'h0b,
    opc_clz  = 5'h0c,
    opc_clo  = 5'h0d,
    opc_sltu = 5'h0e,
    opc_seq  = 5'h0f,
    opc_mfhi = 5'h10
  } alu_opc_e;

  // operations seen by the execute stage.
  typedef enum logic [4:0] {
    op_add, op_sub, op_mul, op_lui,
    op_shl, op_shr, op_asl, op_asr,
    op_and, op_or, op_xor, op_nor,
    op_clz, op_clo, op_sltu, op_seq,
    op_mfhi, op_nop
  } alu_op_e;

  typedef struct packed {
    alu_opc_e               opc;
    logic [`ALU_WIDTH-1:0]  a;
    logic [`ALU_WIDTH-1:0]  b;
    logic                   carry_in;
    logic                   sign;
  } alu_in_t;

  typedef struct packed {
    alu_op_e                op;
    logic [`ALU_WIDTH-1:0]  a;
    logic [`ALU_WIDTH-1:0]  b;
    logic                   carry_in;
    logic                   sign;
    logic                   illegal;
  } alu_req_t;

  typedef struct packed {
    logic [`ALU_WIDTH-1:0]  lo;
    logic [`ALU_WIDTH-1:0]  hi;
    logic                   zero;
    logic                   overflow;
    logic                   writes_hi;
    logic                   reads_hi;
    logic                   illegal;
  } alu_res_t;

  typedef struct packed {
    logic [`ALU_WIDTH-1:0]  result;
    logic                   zero;
    logic                   overflow;
    logic                   illegal;
  } alu_out_t;

endpackage

// ==== src/alu_decode.sv ====
`timescale 1ns/10ps

module alu_decode import alu_pkg::*; (
  input  alu_in_t  in_data,
  output alu_req_t req
);

  alu_op_e op;
  logic    illegal;

  always_comb begin
    illegal = 1'b0;
    case (in_data.opc)
      opc_add:  op = op_add;
      opc_sub:  op = op_sub;
      opc_mul:  op = op_mul;
      opc_lui:  op = op_lui;
      opc_shl:  op = op_shl;
      opc_shr:  op = op_shr;
      opc_asl:  op = op_asl;
      opc_asr:  op = op_asr;
      opc_and:  op = op_and;
      opc_or:   op = op_or;
      opc_xor:  op = op_xor;
      opc_nor:  op = op_nor;
      opc_clz:  op = op_clz;
      opc_clo:  op = op_clo;
      opc_sltu: op = op_sltu;
      opc_seq:  op = op_seq;
      opc_mfhi: op = op_mfhi;
      default: begin
        // unknown opcode, execute does nothing with it.
        op      = op_nop;
        illegal = 1'b1;
      end
    endcase
  end

  always_comb begin
    req.op       = op;
    req.a        = in_data.a;
    req.b        = in_data.b;
    req.carry_in = in_data.carry_in;
    req.sign     = in_data.sign;
    req.illegal  = illegal;
  end

endmodule

// ==== src/pipe_stage.sv ====
`timescale 1ns/10ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     s_valid,
  output logic     s_ready,
  input  payload_t s_data,
  output logic     m_valid,
  input  logic     m_ready,
  output payload_t m_data
);

  logic     valid_q;
  payload_t data_q;

  // free when empty or when the held item leaves this cycle.
  assign s_ready = !valid_q || m_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (s_valid && s_ready) begin
      valid_q <= 1'b1;
    end else if (m_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s_valid && s_ready) begin
      data_q <= s_data;
    end
  end

  assign m_valid = valid_q;
  assign m_data  = data_q;

endmodule

// ==== alu/alu_overflow.sv ====
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_overflow import alu_pkg::*; (
  input  alu_op_e               op,
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  input  logic                  sign,
  output logic                  overflow
);

  localparam int W = `ALU_WIDTH;

  logic [W:0] sum;
  logic [W:0] diff;

  // one extra bit holds the carry or the borrow.
  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b};

  always_comb begin
    case (op)
      op_add: begin
        overflow = sign ? ((a[W-1] == b[W-1]) && (sum[W-1] != a[W-1])) : sum[W];
      end
      op_sub: begin
        overflow = sign ? ((a[W-1] != b[W-1]) && (diff[W-1] != a[W-1])) : diff[W];
      end
      default: overflow = 1'b0;
    endcase
  end

endmodule

// ==== alu/alu_execute.sv ====
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_execute import alu_pkg::*; (
  input  alu_req_t req,
  output alu_res_t res
);

  localparam int W = `ALU_WIDTH;

  logic [2*W-1:0] wide;
  logic [W-1:0]   narrow;
  logic           overflow;

  // halving search, four levels below the 16-bit split.
  function automatic logic [5:0] count_lead_zeros(input logic [W-1:0] v);
    logic [15:0] v16;
    logic [7:0]  v8;
    logic [3:0]  v4;
    logic [5:0]  n;
    n   = '0;
    v16 = '0;
    v8  = '0;
    v4  = '0;
    if (v == '0) begin
      n = 6'd32;
    end else begin
      n[4] = (v[31:16] == 16'h0);
      v16  = n[4] ? v[15:0] : v[31:16];
      n[3] = (v16[15:8] == 8'h0);
      v8   = n[3] ? v16[7:0] : v16[15:8];
      n[2] = (v8[7:4] == 4'h0);
      v4   = n[2] ? v8[3:0] : v8[7:4];
      n[1] = (v4[3:2] == 2'b00);
      n[0] = n[1] ? ~v4[1] : ~v4[3];
    end
    return n;
  endfunction

  alu_overflow u_overflow (
    .op       (req.op),
    .a        (req.a),
    .b        (req.b),
    .sign     (req.sign),
    .overflow (overflow)
  );

  // results that fit in one word.
  always_comb begin
    narrow = '0;
    case (req.op)
      op_add:  narrow = req.a + req.b + {{(W-1){1'b0}}, req.carry_in};
      op_sub:  narrow = req.a - req.b;
      op_lui:  narrow = {req.b[15:0], 16'h0};
      op_shl:  narrow = req.a << 1;
      op_shr:  narrow = req.a >> 1;
      op_asl:  narrow = {req.a[W-2:0], req.a[0]};
      op_asr:  narrow = {req.a[W-1], req.a[W-1:1]};
      op_and:  narrow = req.a & req.b;
      op_or:   narrow = req.a | req.b;
      op_xor:  narrow = req.a ^ req.b;
      op_nor:  narrow = ~(req.a | req.b);
      op_clz:  narrow = {{(W-6){1'b0}}, count_lead_zeros(req.a)};
      // leading ones are the leading zeros of the inverse.
      op_clo:  narrow = {{(W-6){1'b0}}, count_lead_zeros(~req.a)};
      op_sltu: narrow = {{(W-1){1'b0}}, (req.a < req.b)};
      op_seq:  narrow = {{(W-1){1'b0}}, (req.a == req.b)};
      default: narrow = '0;
    endcase
  end

  always_comb begin
    if (req.op == op_mul) begin
      wide = {{W{1'b0}}, req.a} * {{W{1'b0}}, req.b};
    end else begin
      wide = {{W{1'b0}}, narrow};
    end
  end

  always_comb begin
    res.lo        = wide[W-1:0];
    res.hi        = wide[2*W-1:W];
    res.zero      = (wide == '0);
    res.overflow  = overflow;
    res.writes_hi = (req.op == op_mul);
    res.reads_hi  = (req.op == op_mfhi);
    res.illegal   = req.illegal;
  end

endmodule

// ==== src/alu_result.sv ====
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_result import alu_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     res_valid,
  output logic     res_ready,
  input  alu_res_t res,
  output logic     out_valid,
  input  logic     out_ready,
  output alu_out_t out_data
);

  logic [`ALU_WIDTH-1:0] hi_q;
  logic                  out_fire;

  assign out_valid = res_valid;
  assign res_ready = out_ready;
  assign out_fire  = out_valid && out_ready;

  // hi follows the multiplies in the order they leave.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hi_q <= '0;
    end else if (out_fire && res.writes_hi) begin
      hi_q <= res.hi;
    end
  end

  always_comb begin
    if (res.reads_hi) begin
      out_data.result = hi_q;
      out_data.zero   = (hi_q == '0);
    end else begin
      out_data.result = res.lo;
      out_data.zero   = res.zero;
    end
    out_data.overflow = res.overflow;
    out_data.illegal  = res.illegal;
  end

endmodule

// ==== src/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit import alu_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  alu_in_t  in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output alu_out_t out_data
);

  alu_req_t dec_req;
  alu_req_t s1_req;
  logic     s1_valid;
  logic     s1_ready;
  alu_res_t exe_res;
  alu_res_t s2_res;
  logic     s2_valid;
  logic     s2_ready;

  alu_decode u_decode (
    .in_data (in_data),
    .req     (dec_req)
  );

  pipe_stage #(.payload_t(alu_req_t)) u_stage1 (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_valid (in_valid),
    .s_ready (in_ready),
    .s_data  (dec_req),
    .m_valid (s1_valid),
    .m_ready (s1_ready),
    .m_data  (s1_req)
  );

  alu_execute u_execute (
    .req (s1_req),
    .res (exe_res)
  );

  pipe_stage #(.payload_t(alu_res_t)) u_stage2 (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_valid (s1_valid),
    .s_ready (s1_ready),
    .s_data  (exe_res),
    .m_valid (s2_valid),
    .m_ready (s2_ready),
    .m_data  (s2_res)
  );

  alu_result u_result (
    .clk       (clk),
    .arst_n    (arst_n),
    .res_valid (s2_valid),
    .res_ready (s2_ready),
    .res       (s2_res),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/10ps

module clk_gen #(
  parameter int half_period = 50
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

endmodule

// ==== dv/alu_unit_tb.sv ====
`timescale 1ns/10ps

module alu_unit_tb import alu_pkg::*; ();

  localparam int          num_tx         = 400;
  localparam int          timeout_cycles = 4 * num_tx + 50;
  localparam logic [31:0] seed           = 32'hfb15_848b;

  logic     clk;
  logic     arst_n;
  logic     in_valid;
  logic     in_ready;
  alu_in_t  in_data;
  logic     out_valid;
  logic     out_ready;
  alu_out_t out_data;

  alu_in_t     stim_q[$];
  alu_out_t    expect_q[$];
  alu_out_t    exp_item;
  logic [31:0] model_hi;
  logic [31:0] rng_state;
  int          n_acc;
  int          n_out;
  int          ready_errors;
  int          value_errors;
  int          extra_outputs;
  int          missing_outputs;
  int          cycles;

  clk_gen u_clk (.clk(clk));

  alu_unit uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // length of the run of bit_val starting at the msb.
  function automatic logic [31:0] lead_count(input logic [31:0] v, input logic bit_val);
    for (int i = 31; i >= 0; i--) begin
      if (v[i] != bit_val) begin
        return 32'(31 - i);
      end
    end
    return 32'd32;
  endfunction

  // expected response with hi tracked in request order.
  function automatic alu_out_t expected_out(input alu_in_t req);
    logic [63:0] full;
    logic [32:0] ext;
    alu_out_t    o;
    full = '0;
    ext  = '0;
    o    = '0;
    case (req.opc)
      opc_add: begin
        full[31:0] = req.a + req.b + {31'b0, req.carry_in};
        if (req.sign) begin
          ext = $signed({req.a[31], req.a}) + $signed({req.b[31], req.b});
          o.overflow = (ext[32] != ext[31]);
        end else begin
          o.overflow = ((req.a + req.b) < req.a);
        end
      end
      opc_sub: begin
        full[31:0] = req.a - req.b;
        if (req.sign) begin
          ext = $signed({req.a[31], req.a}) - $signed({req.b[31], req.b});
          o.overflow = (ext[32] != ext[31]);
        end else begin
          o.overflow = (req.a < req.b);
        end
      end
      opc_mul: begin
        full     = {32'b0, req.a} * {32'b0, req.b};
        model_hi = full[63:32];
      end
      opc_lui:  full[31:0] = req.b << 16;
      opc_shl:  full[31:0] = req.a << 1;
      opc_shr:  full[31:0] = req.a >> 1;
      opc_asl:  full[31:0] = (req.a << 1) | {31'b0, req.a[0]};
      opc_asr:  full[31:0] = $signed(req.a) >>> 1;
      opc_and:  full[31:0] = req.a & req.b;
      opc_or:   full[31:0] = req.a | req.b;
      opc_xor:  full[31:0] = req.a ^ req.b;
      opc_nor:  full[31:0] = ~(req.a | req.b);
      opc_clz:  full[31:0] = lead_count(req.a, 1'b0);
      opc_clo:  full[31:0] = lead_count(req.a, 1'b1);
      opc_sltu: full[0] = (req.a < req.b);
      opc_seq:  full[0] = (req.a == req.b);
      opc_mfhi: full[31:0] = model_hi;
      default:  o.illegal = 1'b1;
    endcase
    o.result = full[31:0];
    o.zero   = (full == 64'h0);
    return o;
  endfunction

  task automatic add_req(input alu_opc_e opc, input logic [31:0] a, input logic [31:0] b,
                         input logic carry_in, input logic sign);
    alu_in_t r;
    r.opc      = opc;
    r.a        = a;
    r.b        = b;
    r.carry_in = carry_in;
    r.sign     = sign;
    stim_q.push_back(r);
  endtask

  task automatic build_stimulus();
    logic [31:0] corners [4];
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    corners = '{32'h0, 32'hffffffff, 32'h80000000, 32'h00000001};
    for (int i = 0; i < 4; i++) begin
      add_req(opc_clz, corners[i], 32'h0, 1'b0, 1'b0);
      add_req(opc_clo, corners[i], 32'h0, 1'b0, 1'b0);
    end
    // hi starts at zero and then follows each multiply.
    add_req(opc_mfhi, 32'h0, 32'h0, 1'b0, 1'b0);
    add_req(opc_mul, 32'h12345678, 32'h9abcdef0, 1'b0, 1'b0);
    add_req(opc_add, 32'h1, 32'h2, 1'b1, 1'b0);
    add_req(opc_xor, 32'hdeadbeef, 32'h0f0f0f0f, 1'b0, 1'b1);
    add_req(opc_mfhi, 32'h0, 32'h0, 1'b0, 1'b0);
    add_req(opc_mul, 32'hffffffff, 32'hffffffff, 1'b0, 1'b0);
    add_req(opc_mul, 32'h00010000, 32'h00010000, 1'b0, 1'b0);
    add_req(opc_mfhi, 32'h0, 32'h0, 1'b0, 1'b0);
    add_req(opc_mul, 32'h5, 32'h7, 1'b0, 1'b0);
    add_req(opc_mfhi, 32'h0, 32'h0, 1'b0, 1'b0);
    // signed and unsigned limits.
    add_req(opc_add, 32'h7fffffff, 32'h1, 1'b0, 1'b1);
    add_req(opc_add, 32'h80000000, 32'hffffffff, 1'b0, 1'b1);
    add_req(opc_add, 32'h7fffffff, 32'h80000000, 1'b0, 1'b1);
    add_req(opc_sub, 32'h80000000, 32'h1, 1'b0, 1'b1);
    add_req(opc_sub, 32'h7fffffff, 32'hffffffff, 1'b0, 1'b1);
    add_req(opc_sub, 32'h0, 32'h0, 1'b0, 1'b1);
    add_req(opc_add, 32'hffffffff, 32'h1, 1'b0, 1'b0);
    add_req(opc_add, 32'hffffffff, 32'h0, 1'b1, 1'b0);
    add_req(opc_sub, 32'h0, 32'h1, 1'b0, 1'b0);
    add_req(opc_sub, 32'h5, 32'h5, 1'b0, 1'b0);
    add_req(alu_opc_e'(5'h11), 32'h1234, 32'h5678, 1'b1, 1'b1);
    add_req(alu_opc_e'(5'h17), 32'hffffffff, 32'h1, 1'b0, 1'b0);
    add_req(alu_opc_e'(5'h1f), 32'h0, 32'h0, 1'b1, 1'b0);
    corners = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff};
    while (stim_q.size() < num_tx) begin
      draw(r0);
      draw(r1);
      draw(r2);
      // a quarter of the operands come from the limit values.
      if (r0[7:6] == 2'b00) r1 = corners[r0[9:8]];
      if (r0[11:10] == 2'b00) r2 = corners[r0[13:12]];
      add_req(alu_opc_e'(5'(r0[31:16] % 16'd17)), r1, r2, r0[14], r0[15]);
    end
  endtask

  task automatic print_counts();
    $display("accepted %0d, produced %0d, value errors %0d, in_ready errors %0d, %s %0d, %s %0d",
             n_acc, n_out, value_errors, ready_errors, "extra outputs", extra_outputs,
             "missing outputs", missing_outputs);
  endtask

  initial begin
    logic [31:0] r;
    int          idx;
    logic        sent;
    int          held;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    rng_state = seed;
    model_hi  = '0;
    idx       = 0;
    sent      = 1'b0;
    build_stimulus();
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    while (n_acc < num_tx) begin
      @(negedge clk);
      draw(r);
      out_ready = r[0];
      if (sent) in_valid = 1'b0;
      if (!in_valid && idx < num_tx && r[3:1] != 3'd0) begin
        in_valid = 1'b1;
        in_data  = stim_q[idx];
        idx++;
      end
      #1;
      held = n_acc - n_out;
      assert (in_ready || held == 2) else begin
        $display("CHECK FAILED at %0t: in_ready low with %0d items held", $time, held);
        ready_errors++;
      end
      sent = in_valid && in_ready;
      if (sent) begin
        expect_q.push_back(expected_out(in_data));
        n_acc++;
      end
    end
    // drain with the sink always ready so that every held item leaves within two cycles.
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b1;
    repeat (4) @(negedge clk);
    missing_outputs = expect_q.size();
    assert (missing_outputs == 0) else begin
      $display("%0d accepted requests never produced an output", missing_outputs);
    end
    print_counts();
    if (value_errors == 0 && ready_errors == 0 && extra_outputs == 0 && missing_outputs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  always @(negedge clk) begin
    #2;
    if (arst_n && out_valid && out_ready) begin
      n_out++;
      if (expect_q.size() == 0) begin
        $display("output at %0t arrived with no request outstanding", $time);
        extra_outputs++;
      end else begin
        exp_item = expect_q.pop_front();
        assert (out_data.result == exp_item.result) else begin
          $display("CHECK FAILED at %0t: output %0d result %h, expected %h",
                   $time, n_out, out_data.result, exp_item.result);
          value_errors++;
        end
        assert (out_data.zero == exp_item.zero) else begin
          $display("CHECK FAILED at %0t: output %0d zero %b, expected %b",
                   $time, n_out, out_data.zero, exp_item.zero);
          value_errors++;
        end
        assert (out_data.overflow == exp_item.overflow) else begin
          $display("CHECK FAILED at %0t: output %0d overflow %b, expected %b",
                   $time, n_out, out_data.overflow, exp_item.overflow);
          value_errors++;
        end
        assert (out_data.illegal == exp_item.illegal) else begin
          $display("CHECK FAILED at %0t: output %0d illegal %b, expected %b",
                   $time, n_out, out_data.illegal, exp_item.illegal);
          value_errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      print_counts();
      $display("=== FAIL ===");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
+incdir+common
common/alu_pkg.sv
src/alu_decode.sv
src/pipe_stage.sv
alu/alu_overflow.sv
alu/alu_execute.sv
src/alu_result.sv
src/alu_unit.sv
dv/clk_gen.sv
dv/alu_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the alu_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module alu_unit_tb -o alu_unit_sim
./obj_dir/alu_unit_sim > sim.log
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
exit 0
